// ==== hw/luma_chroma_pkg.sv ====
// shared types, sizes and colour tables for the luma/chroma encoder, imported by every RTL block
`default_nettype none

package luma_chroma_pkg;

    typedef logic [3:0] color_index_t;    // one of the 16 palette colours
    typedef logic [5:0] luma_t;           // 6-bit luma dac sample
    typedef logic [5:0] chroma_t;         // 6-bit chroma dac sample
    typedef logic [3:0] hue_t;            // phase offset in 1/16 carrier steps
    typedef logic [1:0] amp_t;            // chroma amplitude, 0 = no colour

    localparam int SAMPLES_PER_PIXEL = 4; // col16x samples per pixel
    localparam int SAMPLE_CNT_W      = $clog2(SAMPLES_PER_PIXEL);
    localparam int QUEUE_DEPTH       = 4;
    localparam int QUEUE_PTR_W       = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W       = QUEUE_PTR_W + 1; // needs to hold QUEUE_DEPTH itself

    localparam chroma_t CHROMA_MID = 6'd32; // carrier centre, no colour
    localparam luma_t   BLANK_LUMA = 6'd8;  // level driven while blanked

    // luma level per colour, black lowest and white at full scale
    localparam luma_t PALETTE_LUMA [16] = '{
        6'd12, 6'd63, 6'd26, 6'd48,   // black white red cyan
        6'd32, 6'd40, 6'd20, 6'd56,   // purple green blue yellow
        6'd32, 6'd20, 6'd40, 6'd26,   // orange brown lt red dk gray
        6'd36, 6'd56, 6'd36, 6'd48    // md gray lt green lt blue lt gray
    };

    // hue as carrier phase offset
    localparam hue_t PALETTE_HUE [16] = '{
        4'd0,  4'd0,  4'd5,  4'd13,
        4'd3,  4'd10, 4'd1,  4'd8,
        4'd6,  4'd7,  4'd5,  4'd0,
        4'd0,  4'd10, 4'd1,  4'd0
    };

    // black, white and the grays carry no chroma
    localparam amp_t PALETTE_AMP [16] = '{
        2'd0, 2'd0, 2'd2, 2'd2,
        2'd2, 2'd2, 2'd3, 2'd1,
        2'd2, 2'd1, 2'd2, 2'd0,
        2'd0, 2'd2, 2'd2, 2'd0
    };

    // one carrier cycle, 8*sin(2*pi*k/16) rounded
    localparam logic signed [4:0] SINE_TABLE [16] = '{
        5'sd0,  5'sd3,  5'sd6,  5'sd7,  5'sd8,  5'sd7,  5'sd6,  5'sd3,
        5'sd0, -5'sd3, -5'sd6, -5'sd7, -5'sd8, -5'sd7, -5'sd6, -5'sd3
    };

    typedef enum logic {
        MOD_BLANK,    // no pixel, output blanked
        MOD_ACTIVE    // holding a pixel for its samples
    } mod_state_t;

endpackage

`default_nettype wire

// ==== hw/pixel_queue.sv ====
// four-entry input FIFO, takes palette indices from the pixel source and feeds the palette stage
`default_nettype none

module pixel_queue
    import luma_chroma_pkg::*;
(
    input  logic         clk_col16x_ntsc,
    input  logic         rst_n,
    input  logic         pix_valid,    // source has an index
    input  color_index_t pix_color,
    output logic         pix_ready,    // room in the queue
    output logic         q_valid,      // head entry present
    output color_index_t q_color,
    input  logic         q_ready       // palette stage takes the head
);

    color_index_t mem [QUEUE_DEPTH];    // entry storage, payload only
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;      // occupancy 0..QUEUE_DEPTH
    logic                   push;
    logic                   pop;

    assign pix_ready = (count < QUEUE_CNT_W'(QUEUE_DEPTH));
    assign q_valid   = (count != '0);     // from the count register only
    assign q_color   = mem[rd_ptr];       // registered head entry

    assign push = pix_valid && pix_ready;
    assign pop  = q_valid && q_ready;

    // storage write, no reset on the entries
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (push)
        begin
            mem[wr_ptr] <= pix_color;
        end
    end

    // pointers and count
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth 4
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/palette_stage.sv ====
// one-entry pipeline register, looks up luma, hue and amplitude for each palette index
`default_nettype none

module palette_stage
    import luma_chroma_pkg::*;
(
    input  logic         clk_col16x_ntsc,
    input  logic         rst_n,
    input  logic         q_valid,
    input  color_index_t q_color,
    output logic         q_ready,
    output logic         pal_valid,    // lookup result held
    output luma_t        pal_luma,
    output hue_t         pal_hue,
    output amp_t         pal_amp,
    input  logic         pal_ready     // modulator takes the result
);

    logic load;     // accept a new index this cycle

    // free slot, or the held result leaves this cycle
    assign q_ready = !pal_valid || pal_ready;
    assign load    = q_valid && q_ready;

    // valid flag
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            pal_valid <= 1'b0;
        end
        else if (load)
        begin
            pal_valid <= 1'b1;
        end
        else if (pal_ready)
        begin
            pal_valid <= 1'b0;   // taken, nothing behind it
        end
    end

    // table lookup captured on accept, held otherwise
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (load)
        begin
            pal_luma <= PALETTE_LUMA[q_color];
            pal_hue  <= PALETTE_HUE[q_color];
            pal_amp  <= PALETTE_AMP[q_color];
        end
    end

endmodule

`default_nettype wire

// ==== hw/chroma_modulator.sv ====
// output stage, holds each pixel for its samples and turns hue and amplitude into carrier samples
`default_nettype none

module chroma_modulator
    import luma_chroma_pkg::*;
(
    input  logic  clk_col16x_ntsc,
    input  logic  rst_n,
    input  logic  pal_valid,
    input  luma_t pal_luma,
    input  hue_t  pal_hue,
    input  amp_t  pal_amp,
    output logic  pal_ready,    // last sample or blanked
    output luma_t luma,         // luma dac value
    output chroma_t chroma,     // chroma dac value
    output logic  luma_sink     // pulls the luma line low while blanked
);

    mod_state_t               state;
    logic [SAMPLE_CNT_W-1:0]  sample_cnt;   // sample within current pixel
    hue_t                     phase;        // free-running carrier phase
    luma_t                    hold_luma;    // current pixel
    hue_t                     hold_hue;
    amp_t                     hold_amp;
    logic                     last_sample;
    logic                     take;
    hue_t                     carrier_idx;
    logic signed [4:0]        sine_val;
    logic signed [2:0]        amp_s;
    logic signed [7:0]        chroma_term;
    logic signed [7:0]        chroma_sum;

    assign last_sample = (state == MOD_ACTIVE) &&
                         (sample_cnt == SAMPLE_CNT_W'(SAMPLES_PER_PIXEL - 1));
    assign pal_ready   = (state == MOD_BLANK) || last_sample;
    assign take        = pal_valid && pal_ready;

    // carrier phase, 16 steps per colour cycle, runs through blanking too
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            phase <= '0;
        end
        else
        begin
            phase <= phase + 1'b1;   // wraps mod 16
        end
    end

    // pixel sequencing
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            state      <= MOD_BLANK;
            sample_cnt <= '0;
        end
        else if (take)
        begin
            state      <= MOD_ACTIVE;  // next pixel follows with no gap
            sample_cnt <= '0;
        end
        else if (last_sample)
        begin
            state      <= MOD_BLANK;   // nothing waiting
            sample_cnt <= '0;
        end
        else if (state == MOD_ACTIVE)
        begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // pixel payload
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (take)
        begin
            hold_luma <= pal_luma;
            hold_hue  <= pal_hue;
            hold_amp  <= pal_amp;
        end
    end

    // chroma = mid + amp * sin(phase + hue), range 8..56
    assign carrier_idx = phase + hold_hue;            // mod 16 by width
    assign sine_val    = SINE_TABLE[carrier_idx];
    assign amp_s       = $signed({1'b0, hold_amp});
    assign chroma_term = amp_s * sine_val;
    assign chroma_sum  = $signed({2'b00, CHROMA_MID}) + chroma_term;

    // output forming, follows the registered state each sample
    always_comb
    begin
        if (state == MOD_ACTIVE)
        begin
            luma      = hold_luma;
            chroma    = chroma_sum[5:0];
            luma_sink = 1'b0;
        end
        else
        begin
            luma      = BLANK_LUMA;
            chroma    = CHROMA_MID;
            luma_sink = 1'b1;        // external network pulls luma low
        end
    end

endmodule

`default_nettype wire

// ==== hw/luma_chroma_top.sv ====
// luma/chroma encoder top, pixel indices in and per-sample luma, chroma and luma_sink out
`default_nettype none

module luma_chroma_top
    import luma_chroma_pkg::*;
(
    input  logic         clk_col16x_ntsc,   // 16 samples per ntsc carrier cycle
    input  logic         rst_n,
    input  logic         pix_valid,
    input  color_index_t pix_color,
    output logic         pix_ready,
    output luma_t        luma,
    output chroma_t      chroma,
    output logic         luma_sink
);

    logic         q_valid;      // queue head to palette stage
    logic         q_ready;
    color_index_t q_color;
    logic         pal_valid;    // palette result to modulator
    logic         pal_ready;
    luma_t        pal_luma;
    hue_t         pal_hue;
    amp_t         pal_amp;

    pixel_queue i_pixel_queue (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .pix_valid       (pix_valid),
        .pix_color       (pix_color),
        .pix_ready       (pix_ready),
        .q_valid         (q_valid),
        .q_color         (q_color),
        .q_ready         (q_ready)
    );

    palette_stage i_palette_stage (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .q_valid         (q_valid),
        .q_color         (q_color),
        .q_ready         (q_ready),
        .pal_valid       (pal_valid),
        .pal_luma        (pal_luma),
        .pal_hue         (pal_hue),
        .pal_amp         (pal_amp),
        .pal_ready       (pal_ready)
    );

    chroma_modulator i_chroma_modulator (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .pal_valid       (pal_valid),
        .pal_luma        (pal_luma),
        .pal_hue         (pal_hue),
        .pal_amp         (pal_amp),
        .pal_ready       (pal_ready),
        .luma            (luma),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

endmodule

`default_nettype wire

// ==== tests/tb_luma_chroma_assert.sv ====
// concurrent checks on the internal handshakes, queue fill and blanking, bound into the encoder top
`default_nettype none

module tb_luma_chroma_assert
    import luma_chroma_pkg::*;
(
    input logic                   clk_col16x_ntsc,
    input logic                   rst_n,
    input logic                   pix_ready,
    input logic [QUEUE_CNT_W-1:0] q_count,      // queue occupancy
    input logic                   pal_valid,
    input logic                   pal_ready,
    input luma_t                  pal_luma,
    input hue_t                   pal_hue,
    input amp_t                   pal_amp,
    input chroma_t                chroma,
    input logic                   luma_sink
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;    // read by the testbench top

    // an offered palette result holds until the modulator takes it
    a_pal_hold: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
        (pal_valid && !pal_ready) |=>
            (pal_valid && $stable(pal_luma) && $stable(pal_hue) && $stable(pal_amp)))
    else
    begin
        fail_count++;
        $error("pal handshake changed while pal_ready was low");
    end

    // blanked output carries no colour
    a_blank_chroma: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
        luma_sink |-> (chroma == CHROMA_MID))
    else
    begin
        fail_count++;
        $error("chroma off centre while luma_sink is high");
    end

    // full queue refuses the source
    a_full_stall: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
        (q_count == QUEUE_CNT_W'(QUEUE_DEPTH)) |-> !pix_ready)
    else
    begin
        fail_count++;
        $error("pix_ready high with a full queue");
    end

endmodule

`default_nettype wire

// ==== tests/tb_luma_chroma.sv ====
// testbench for the luma/chroma encoder, plays the pattern file into the DUT and checks each sample
`default_nettype none

module tb_luma_chroma
    import luma_chroma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic         clk_col16x_ntsc = 1'b0;
    logic         rst_n;
    logic         pix_valid;
    color_index_t pix_color;
    logic         pix_ready;
    luma_t        luma;
    chroma_t      chroma;
    logic         luma_sink;

    logic [7:0]  pat_mem [0:255];    // five bytes per pixel line
    int          num_patterns;
    int          gap_sum;            // listed gaps only
    int          watchdog_cycles;
    logic [31:0] rng_state;
    bit          patterns_loaded;
    bit          stream_done;
    bit          saw_ready_low;      // queue filled at least once
    int          cycle;              // edges since reset release, phase = cycle mod 16
    int          accepted_cnt;
    int          finished_cnt;
    int          last_start;         // first sample edge of the newest pixel
    int          next_start;
    int          exp_start [$];      // expected pixels in acceptance order
    luma_t       exp_luma [$];
    hue_t        exp_hue [$];
    amp_t        exp_amp [$];

    luma_chroma_top i_dut (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .pix_valid       (pix_valid),
        .pix_color       (pix_color),
        .pix_ready       (pix_ready),
        .luma            (luma),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

    bind luma_chroma_top tb_luma_chroma_assert i_assert (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .pix_ready       (pix_ready),
        .q_count         (i_pixel_queue.count),
        .pal_valid       (pal_valid),
        .pal_ready       (pal_ready),
        .pal_luma        (pal_luma),
        .pal_hue         (pal_hue),
        .pal_amp         (pal_amp),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

    always #5 clk_col16x_ntsc = ~clk_col16x_ntsc;    // 10 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 8*sin(2*pi*k/16) rounded, odd symmetry over the cycle
    function automatic int sine_step(input int k);
        int mag;
        case (k % 8)
            0:       mag = 0;
            1:       mag = 3;
            2:       mag = 6;
            3:       mag = 7;
            4:       mag = 8;
            5:       mag = 7;
            6:       mag = 6;
            default: mag = 3;
        endcase
        return ((k % 16) >= 8) ? -mag : mag;
    endfunction

    // centre plus amplitude times carrier at phase + hue
    function automatic chroma_t expected_chroma(input int cyc, input hue_t hue, input amp_t amp);
        int value;
        value = int'(CHROMA_MID) + int'(amp) * sine_step((cyc + int'(hue)) % 16);
        return chroma_t'(value);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_luma(input string name, input luma_t exp_val, input luma_t act_val);
        if (act_val !== exp_val)
        begin
            abort_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                                $time, name, exp_val, act_val));
        end
    endtask

    task automatic check_chroma(input string name, input chroma_t exp_val, input chroma_t act_val);
        if (act_val !== exp_val)
        begin
            abort_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                                $time, name, exp_val, act_val));
        end
    endtask

    task automatic check_sink(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
        begin
            abort_run($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
                                $time, name, exp_val, act_val));
        end
    endtask

    // hold valid and colour steady until the transfer edge
    task automatic send_pixel(input color_index_t color, input int idle);
        repeat (idle) @(negedge clk_col16x_ntsc);
        pix_valid = 1'b1;
        pix_color = color;
        @(posedge clk_col16x_ntsc);
        while (!pix_ready)
        begin
            @(posedge clk_col16x_ntsc);
        end
        @(negedge clk_col16x_ntsc);
        pix_valid = 1'b0;
    endtask

    // monitor, samples hold pre-edge values on the rising edge
    always @(posedge clk_col16x_ntsc)
    begin
        if (rst_n)
        begin
            if (pix_valid && pix_ready)
            begin
                next_start = cycle + 3;                         // latency into an empty pipeline
                if (last_start + SAMPLES_PER_PIXEL > next_start)
                begin
                    next_start = last_start + SAMPLES_PER_PIXEL; // queued behind the current pixel
                end
                exp_start.push_back(next_start);
                exp_luma.push_back(luma_t'(pat_mem[5 * accepted_cnt + 2]));
                exp_hue.push_back(hue_t'(pat_mem[5 * accepted_cnt + 3]));
                exp_amp.push_back(amp_t'(pat_mem[5 * accepted_cnt + 4]));
                last_start = next_start;
                accepted_cnt++;
            end
            if (!pix_ready)
            begin
                saw_ready_low = 1'b1;
            end
            if (cycle == 0)
            begin
                check_sink("pix_ready", 1'b1, pix_ready);
            end
            if (exp_start.size() > 0 && exp_start[0] <= cycle)
            begin
                check_sink("luma_sink", 1'b0, luma_sink);
                check_luma("luma", exp_luma[0], luma);
                check_chroma("chroma", expected_chroma(cycle, exp_hue[0], exp_amp[0]), chroma);
                if (cycle == exp_start[0] + SAMPLES_PER_PIXEL - 1)
                begin
                    exp_start.pop_front();    // pixel complete
                    exp_luma.pop_front();
                    exp_hue.pop_front();
                    exp_amp.pop_front();
                    finished_cnt++;
                end
            end
            else
            begin
                check_sink("luma_sink", 1'b1, luma_sink);
                check_luma("luma", BLANK_LUMA, luma);
                check_chroma("chroma", CHROMA_MID, chroma);
                if (num_patterns > 0 && finished_cnt == num_patterns)
                begin
                    stream_done = 1'b1;    // all out and blank again
                end
            end
            cycle++;
        end
    end

    always @(negedge clk_col16x_ntsc)
    begin
        if (i_dut.i_assert.fail_count != 0)
        begin
            abort_run("a concurrent assertion on the DUT failed");
        end
    end

    initial
    begin
        rst_n           = 1'b0;
        pix_valid       = 1'b0;
        pix_color       = '0;
        rng_state       = 32'h30bb;
        patterns_loaded = 1'b0;
        stream_done     = 1'b0;
        saw_ready_low   = 1'b0;
        cycle           = 0;
        accepted_cnt    = 0;
        finished_cnt    = 0;
        last_start      = -100;
        num_patterns    = 0;
        gap_sum         = 0;
        for (int i = 0; i < 256; i++)
        begin
            pat_mem[i] = 8'hff;    // end marker, colours stop at 0f
        end
        $readmemh("tests/luma_chroma_patterns.hex", pat_mem);
        while (5 * num_patterns + 4 < 256 && pat_mem[5 * num_patterns] != 8'hff)
        begin
            gap_sum = gap_sum + int'(pat_mem[5 * num_patterns + 1]);
            num_patterns++;
        end
        watchdog_cycles = 20 * num_patterns + gap_sum + 200;
        patterns_loaded = 1'b1;
        repeat (10) @(negedge clk_col16x_ntsc);
        rst_n = 1'b1;
        for (int i = 0; i < num_patterns; i++)
        begin
            rng_state = xorshift32(rng_state);
            send_pixel(color_index_t'(pat_mem[5 * i]),
                       int'(pat_mem[5 * i + 1]) + int'(rng_state[1:0]));
        end
        wait (stream_done);
        @(negedge clk_col16x_ntsc);
        if (!saw_ready_low)
        begin
            abort_run("pix_ready never went low, the zero-gap burst did not fill the queue");
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

    // watchdog, budget counted from the pattern list
    initial
    begin
        wait (patterns_loaded);
        repeat (watchdog_cycles + 10) @(posedge clk_col16x_ntsc);
        abort_run("timeout, the output did not finish the pattern stream");
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/luma_chroma_pkg.sv
hw/pixel_queue.sv
hw/palette_stage.sv
hw/chroma_modulator.sv
hw/luma_chroma_top.sv
tests/tb_luma_chroma_assert.sv
tests/tb_luma_chroma.sv

// ==== tests/luma_chroma_patterns.hex ====
// palette index, gap cycles, expected luma, expected hue phase, expected chroma amplitude
// one pixel per line, every column in hex
00 03 0c 00 00
01 00 3f 00 00
02 00 1a 05 02
03 28 30 0d 02
04 00 20 03 02
05 00 28 0a 02
0c 28 24 00 00
06 20 14 01 03
07 00 38 08 01
08 00 20 06 02
09 00 14 07 01
0a 00 28 05 02
0b 00 1a 00 00
0d 00 38 0a 02
0e 00 24 01 02
0f 00 30 00 00
00 00 0c 00 00
01 00 3f 00 00
02 00 1a 05 02
03 00 30 0d 02
04 00 20 03 02
05 00 28 0a 02
06 00 14 01 03
07 00 38 08 01
08 00 20 06 02
09 00 14 07 01
0a 00 28 05 02
0c 00 24 00 00
0e 00 24 01 02
0f 28 30 00 00
